// File: verilog/fm_defines.svh
////////////////////////////////////////
// FM register front end constants
// Bus and field widths, register numbers
// and the busy tick count
////////////////////////////////////////

`ifndef FM_DEFINES_SVH
`define FM_DEFINES_SVH

`define FM_DATA_W      8
`define FM_TA_W        10   // Timer A value
`define FM_TB_W        8    // Timer B value
`define FM_PCM_W       9    // DAC sample
`define FM_BUSY_TICKS  32   // Synth ticks per data write

// Global register numbers, part 0
`define FM_REG_TEST    8'h21
`define FM_REG_LFO     8'h22
`define FM_REG_CLKA1   8'h24
`define FM_REG_CLKA2   8'h25
`define FM_REG_CLKB    8'h26
`define FM_REG_TIMER   8'h27
`define FM_REG_KON     8'h28
`define FM_REG_PCM     8'h2A
`define FM_REG_PCM_EN  8'h2B
`define FM_REG_DACTEST 8'h2C
`define FM_REG_CLK_N6  8'h2D   // Divider select on address write
`define FM_REG_CLK_N3  8'h2E
`define FM_REG_CLK_N2  8'h2F

`endif

// File: verilog/fm_pkg.sv
////////////////////////////////////////
// FM register front end types
// Write record, divider codes, global
// register groups and update record
////////////////////////////////////////

`include "fm_defines.svh"

package fm_pkg;

    // One host data write
    typedef struct packed {
        logic                   valid;
        logic                   part;   // Upper bank
        logic [7:0]             sel;
        logic [`FM_DATA_W-1:0]  data;
    } reg_wr_t;

    typedef enum logic [1:0] {
        DIV_CMD_NONE,
        DIV_CMD_N6,
        DIV_CMD_N3,
        DIV_CMD_N2
    } div_cmd_e;

    typedef enum logic [1:0] {
        DIV_2  = 2'b00,
        DIV_2B = 2'b01,
        DIV_6  = 2'b10,
        DIV_3  = 2'b11
    } div_mode_e;

    typedef struct packed {
        logic [`FM_TA_W-1:0]  value_a;
        logic [`FM_TB_W-1:0]  value_b;
        logic                 load_a;
        logic                 load_b;
        logic                 irq_en_a;
        logic                 irq_en_b;
        logic                 clr_a;    // One-shot
        logic                 clr_b;    // One-shot
        logic                 fast;
        logic                 csm;
        logic                 effect;   // Ch3 special mode
    } timer_cfg_t;

    typedef struct packed {
        logic       en;
        logic [2:0] freq;
    } lfo_cfg_t;

    typedef struct packed {
        logic eg_stop;
        logic pg_stop;
    } test_cfg_t;

    typedef struct packed {
        logic [`FM_PCM_W-1:0] value;
        logic                 en;
        logic                 wr;       // One-shot sample strobe
    } pcm_t;

    typedef enum logic [3:0] {
        UPD_NONE, UPD_KEYON, UPD_FNUM_LO, UPD_ALG, UPD_PMS, UPD_DT1,
        UPD_TL, UPD_KS_AR, UPD_AMEN_DR, UPD_SR, UPD_SL_RR, UPD_SSGEG
    } upd_kind_e;

    // Held record for the operator register file
    typedef struct packed {
        upd_kind_e              kind;
        logic [2:0]             ch;
        logic [1:0]             op;
        logic [`FM_DATA_W-1:0]  data;
    } op_update_t;

endpackage

// File: verilog/fm_bus_if.sv
////////////////////////////////////////
// Host port of the FM register block
// Register select latch, divider
// commands and busy tick counter
////////////////////////////////////////

`timescale 1ns/10ps
`include "fm_defines.svh"

module fm_bus_if import fm_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`FM_DATA_W-1:0]  din,
    input  logic                   write,
    input  logic [1:0]             addr,
    input  logic                   clk_en,
    output reg_wr_t                reg_wr,
    output div_cmd_e               div_cmd,
    output logic                   busy
);

    localparam int BUSY_CW = $clog2(`FM_BUSY_TICKS);

    logic [7:0]         sel;
    logic               part;
    logic               old_write;  // For edge detect
    logic [BUSY_CW-1:0] busy_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            sel       <= 8'h00;
            part      <= 1'b0;
            old_write <= 1'b0;
        end else begin
            old_write <= write;
            if (write && !addr[0]) begin
                sel  <= din;
                part <= addr[1];
            end
        end
    end

    // Data write goes out in the same cycle
    assign reg_wr = '{valid: write && addr[0], part: part, sel: sel, data: din};

    always_comb begin
        div_cmd = DIV_CMD_NONE;
        if (write && !addr[0]) begin
            case (din)
                `FM_REG_CLK_N6: div_cmd = DIV_CMD_N6;
                `FM_REG_CLK_N3: div_cmd = DIV_CMD_N3;
                `FM_REG_CLK_N2: div_cmd = DIV_CMD_N2;
                default:        div_cmd = DIV_CMD_NONE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (!old_write && write && addr[0]) begin
            busy     <= 1'b1;   // Data writes only
            busy_cnt <= '0;
        end else if (clk_en) begin
            if (busy_cnt == BUSY_CW'(`FM_BUSY_TICKS - 1))
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

    a_busy_cause: assert property (@(posedge clk) disable iff (rst)
        $rose(busy) |-> $past(write && addr[0]));

endmodule

// File: verilog/fm_clk_div.sv
////////////////////////////////////////
// FM tick clock enable
// Divider setting and period counter
////////////////////////////////////////

`timescale 1ns/10ps

module fm_clk_div import fm_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  div_cmd_e div_cmd,
    output logic     clk_en
);

    div_mode_e  mode;
    logic [2:0] cnt;
    logic [2:0] last;   // Period minus one

    always_ff @(posedge clk) begin
        if (rst) begin
            mode <= DIV_6;
        end else begin
            case (div_cmd)
                DIV_CMD_N6: mode <= div_mode_e'({1'b1, mode[0]});
                DIV_CMD_N3: mode <= div_mode_e'({mode[1], 1'b1});
                DIV_CMD_N2: mode <= DIV_2;
                default:    mode <= mode;
            endcase
        end
    end

    always_comb begin
        case (mode)
            DIV_6:   last = 3'd5;
            DIV_3:   last = 3'd2;
            default: last = 3'd1;   // Both /2 codes
        endcase
    end

    // >= catches a shorter period set mid count
    assign clk_en = cnt >= last;

    always_ff @(posedge clk) begin
        if (rst)
            cnt <= 3'd0;
        else if (clk_en)
            cnt <= 3'd0;
        else
            cnt <= cnt + 3'd1;
    end

    a_en_pulse: assert property (@(posedge clk) disable iff (rst)
        clk_en |=> !clk_en);

endmodule

// File: verilog/fm_global_regs.sv
////////////////////////////////////////
// FM global registers
// Timers, LFO, test bits and DAC sample,
// one-shot fields cleared on idle ticks
////////////////////////////////////////

`timescale 1ns/10ps
`include "fm_defines.svh"

module fm_global_regs import fm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  reg_wr_t    reg_wr,
    output timer_cfg_t timer,
    output lfo_cfg_t   lfo,
    output test_cfg_t  test,
    output pcm_t       pcm
);

    logic [`FM_DATA_W-1:0] d;

    assign d = reg_wr.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            timer <= '0;
            lfo   <= '0;
            test  <= '0;
            pcm   <= '0;
        end else if (reg_wr.valid) begin
            if (!reg_wr.part) begin    // Upper bank has no globals
                case (reg_wr.sel)
                    `FM_REG_TEST: begin
                        test.eg_stop <= d[5];
                        test.pg_stop <= d[3];
                        timer.fast   <= d[2];
                    end
                    `FM_REG_LFO: begin
                        lfo.en   <= d[3];
                        lfo.freq <= d[2:0];
                    end
                    `FM_REG_CLKA1: timer.value_a[9:2] <= d;
                    `FM_REG_CLKA2: timer.value_a[1:0] <= d[1:0];
                    `FM_REG_CLKB:  timer.value_b      <= d;
                    `FM_REG_TIMER: begin
                        timer.effect   <= |d[7:6];
                        timer.csm      <= d[7:6] == 2'b10;
                        timer.clr_b    <= d[5];
                        timer.clr_a    <= d[4];
                        timer.irq_en_b <= d[3];
                        timer.irq_en_a <= d[2];
                        timer.load_b   <= d[1];
                        timer.load_a   <= d[0];
                    end
                    // Offset binary to signed with LSB forced high
                    `FM_REG_PCM:     pcm.value    <= {~d[7], d[6:0], 1'b1};
                    `FM_REG_PCM_EN:  pcm.en       <= d[7];
                    `FM_REG_DACTEST: pcm.value[0] <= d[3];
                    default: ;
                endcase
            end
            pcm.wr <= reg_wr.sel == `FM_REG_PCM;
        end else if (clk_en) begin
            // Strobes last until an idle tick
            timer.clr_a <= 1'b0;
            timer.clr_b <= 1'b0;
            pcm.wr      <= 1'b0;
        end
    end

    a_wr_clear: assert property (@(posedge clk) disable iff (rst)
        reg_wr.valid ##1 (!reg_wr.valid && clk_en) |=> !pcm.wr);

endmodule

// File: verilog/fm_update_decode.sv
////////////////////////////////////////
// Channel and operator write decoder
// Classifies data writes into a held
// update record for the register file
////////////////////////////////////////

`timescale 1ns/10ps
`include "fm_defines.svh"

module fm_update_decode import fm_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  reg_wr_t    reg_wr,
    output op_update_t upd
);

    upd_kind_e kind;

    always_comb begin
        if (reg_wr.sel == `FM_REG_KON && !reg_wr.part) begin
            kind = UPD_KEYON;
        end else if (reg_wr.sel[1:0] == 2'b11) begin
            kind = UPD_NONE;    // No fourth channel per bank
        end else begin
            casez (reg_wr.sel)
                8'hA0, 8'hA1, 8'hA2: kind = UPD_FNUM_LO;
                8'hB0, 8'hB1, 8'hB2: kind = UPD_ALG;
                8'hB4, 8'hB5, 8'hB6: kind = UPD_PMS;
                8'h3?:   kind = UPD_DT1;     // Also MUL
                8'h4?:   kind = UPD_TL;
                8'h5?:   kind = UPD_KS_AR;
                8'h6?:   kind = UPD_AMEN_DR;
                8'h7?:   kind = UPD_SR;
                8'h8?:   kind = UPD_SL_RR;
                8'h9?:   kind = UPD_SSGEG;
                default: kind = UPD_NONE;
            endcase
        end
    end

    // Record holds until the next data write
    always_ff @(posedge clk) begin
        if (rst) begin
            upd.kind <= UPD_NONE;
            upd.ch   <= 3'd0;
            upd.op   <= 2'd0;
            upd.data <= '0;
        end else if (reg_wr.valid) begin
            upd.kind <= kind;
            upd.ch   <= {reg_wr.part, reg_wr.sel[1:0]};
            upd.op   <= reg_wr.sel[3:2];    // Slot order S1 S3 S2 S4
            upd.data <= reg_wr.data;
        end
    end

    a_no_ch3: assert property (@(posedge clk) disable iff (rst)
        (upd.kind != UPD_NONE && upd.kind != UPD_KEYON) |-> upd.ch[1:0] != 2'b11);

endmodule

// File: verilog/fm_mmr_top.sv
////////////////////////////////////////
// FM host register front end
// Bus port, tick divider, global
// registers and update decoder
////////////////////////////////////////

`timescale 1ns/10ps
`include "fm_defines.svh"

module fm_mmr_top import fm_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`FM_DATA_W-1:0]  din,
    input  logic                   write,
    input  logic [1:0]             addr,
    output logic                   clk_en,
    output logic                   busy,
    output timer_cfg_t             timer,
    output lfo_cfg_t               lfo,
    output test_cfg_t              test,
    output pcm_t                   pcm,
    output op_update_t             upd
);

    reg_wr_t  reg_wr;
    div_cmd_e div_cmd;

    fm_bus_if fm_bus_if_inst (
        .clk     (clk),
        .rst     (rst),
        .din     (din),
        .write   (write),
        .addr    (addr),
        .clk_en  (clk_en),
        .reg_wr  (reg_wr),
        .div_cmd (div_cmd),
        .busy    (busy)
    );

    fm_clk_div fm_clk_div_inst (
        .clk     (clk),
        .rst     (rst),
        .div_cmd (div_cmd),
        .clk_en  (clk_en)
    );

    fm_global_regs fm_global_regs_inst (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .reg_wr (reg_wr),
        .timer  (timer),
        .lfo    (lfo),
        .test   (test),
        .pcm    (pcm)
    );

    fm_update_decode fm_update_decode_inst (
        .clk    (clk),
        .rst    (rst),
        .reg_wr (reg_wr),
        .upd    (upd)
    );

endmodule

// File: tb/fm_mmr_model.svh
////////////////////////////////////////
// Expected state of the FM front end
// Global registers, update record and
// divider setting, kept by the testbench
////////////////////////////////////////

`ifndef FM_MMR_MODEL_SVH
`define FM_MMR_MODEL_SVH

timer_cfg_t exp_timer;
lfo_cfg_t   exp_lfo;
test_cfg_t  exp_test;
pcm_t       exp_pcm;
op_update_t exp_upd;
logic [1:0] exp_div;    // Divider setting bits

task automatic reset_expected();
    exp_timer = '0;
    exp_lfo   = '0;
    exp_test  = '0;
    exp_pcm   = '0;
    exp_upd   = '0;
    exp_upd.kind = UPD_NONE;
    exp_div   = 2'b10;  // Slowest rate
endtask

function automatic int tick_period(input logic [1:0] div);
    if (div == 2'b10)
        return 6;
    if (div == 2'b11)
        return 3;
    return 2;
endfunction

// Address writes only move the divider bits
task automatic apply_select(input logic [7:0] sel);
    if (sel == `FM_REG_CLK_N6)
        exp_div[1] = 1'b1;
    else if (sel == `FM_REG_CLK_N3)
        exp_div[0] = 1'b1;
    else if (sel == `FM_REG_CLK_N2)
        exp_div = 2'b00;
endtask

function automatic upd_kind_e classify_write(input logic part, input logic [7:0] sel);
    if (sel == `FM_REG_KON && !part)
        return UPD_KEYON;
    if (sel[1:0] == 2'b11)
        return UPD_NONE;
    if (sel[7:2] == 6'b1010_00)
        return UPD_FNUM_LO;
    if (sel[7:2] == 6'b1011_00)
        return UPD_ALG;
    if (sel[7:2] == 6'b1011_01)
        return UPD_PMS;
    case (sel[7:4])
        4'h3: return UPD_DT1;
        4'h4: return UPD_TL;
        4'h5: return UPD_KS_AR;
        4'h6: return UPD_AMEN_DR;
        4'h7: return UPD_SR;
        4'h8: return UPD_SL_RR;
        4'h9: return UPD_SSGEG;
        default: return UPD_NONE;
    endcase
endfunction

task automatic apply_data_write(input logic part, input logic [7:0] sel, input logic [7:0] d);
    if (!part) begin
        if (sel == `FM_REG_TEST) begin
            exp_test.eg_stop = d[5];
            exp_test.pg_stop = d[3];
            exp_timer.fast   = d[2];
        end else if (sel == `FM_REG_LFO) begin
            exp_lfo.en   = d[3];
            exp_lfo.freq = d[2:0];
        end else if (sel == `FM_REG_CLKA1) begin
            exp_timer.value_a[9:2] = d;
        end else if (sel == `FM_REG_CLKA2) begin
            exp_timer.value_a[1:0] = d[1:0];
        end else if (sel == `FM_REG_CLKB) begin
            exp_timer.value_b = d;
        end else if (sel == `FM_REG_TIMER) begin
            {exp_timer.clr_b, exp_timer.clr_a}       = d[5:4];
            {exp_timer.irq_en_b, exp_timer.irq_en_a} = d[3:2];
            {exp_timer.load_b, exp_timer.load_a}     = d[1:0];
            exp_timer.effect = d[7] || d[6];
            exp_timer.csm    = d[7] && !d[6];
        end else if (sel == `FM_REG_PCM) begin
            exp_pcm.value = {~d[7], d[6:0], 1'b1};
        end else if (sel == `FM_REG_PCM_EN) begin
            exp_pcm.en = d[7];
        end else if (sel == `FM_REG_DACTEST) begin
            exp_pcm.value[0] = d[3];
        end
    end
    exp_pcm.wr   = (sel == `FM_REG_PCM);   // Any part
    exp_upd.kind = classify_write(part, sel);
    exp_upd.ch   = {part, sel[1:0]};
    exp_upd.op   = sel[3:2];
    exp_upd.data = d;
endtask

// Strobes drop on the first idle tick
task automatic clear_one_shots();
    exp_timer.clr_a = 1'b0;
    exp_timer.clr_b = 1'b0;
    exp_pcm.wr      = 1'b0;
endtask

`endif

// File: tb/fm_mmr_tb.sv
////////////////////////////////////////
// Testbench for the FM register front end
// Random host writes checked against
// an expected-state model
////////////////////////////////////////

`timescale 1ns/10ps
`include "fm_defines.svh"

module fm_mmr_tb import fm_pkg::*; ();

    localparam int N_GLOBAL  = 60;
    localparam int N_PCM     = 30;
    localparam int N_ONESHOT = 12;
    localparam int N_UPD     = 60;
    localparam int N_DIV     = 12;  // Three selects with three writes after each
    localparam int N_TRANS   = N_GLOBAL + N_PCM + N_ONESHOT + N_UPD + N_DIV;
    localparam longint WATCHDOG_NS = 64'(N_TRANS) * 40 * 6 * 20 + 20000;
    localparam int BUSY_LIMIT = 32 * 6 + 8;

    logic       clk;
    logic       rst;
    logic [7:0] din;
    logic       write;
    logic [1:0] addr;
    logic       clk_en;
    logic       busy;
    timer_cfg_t timer;
    lfo_cfg_t   lfo;
    test_cfg_t  test;
    pcm_t       pcm;
    op_update_t upd;

    `include "fm_mmr_model.svh"

    fm_mmr_top fm_mmr_top_inst (
        .clk    (clk),
        .rst    (rst),
        .din    (din),
        .write  (write),
        .addr   (addr),
        .clk_en (clk_en),
        .busy   (busy),
        .timer  (timer),
        .lfo    (lfo),
        .test   (test),
        .pcm    (pcm),
        .upd    (upd)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished, the run hangs");
        $display("TB FAILED");
        $fatal(1, "timeout");
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        report_error($sformatf("FAIL %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic compare_timer(input string name, input timer_cfg_t exp, input timer_cfg_t act);
        if (act !== exp) report_mismatch({name, " timer"}, 32'(exp), 32'(act));
    endtask

    task automatic compare_lfo(input string name, input lfo_cfg_t exp, input lfo_cfg_t act);
        if (act !== exp) report_mismatch({name, " lfo"}, 32'(exp), 32'(act));
    endtask

    task automatic compare_test(input string name, input test_cfg_t exp, input test_cfg_t act);
        if (act !== exp) report_mismatch({name, " test"}, 32'(exp), 32'(act));
    endtask

    task automatic compare_pcm(input string name, input pcm_t exp, input pcm_t act);
        if (act !== exp) report_mismatch({name, " pcm"}, 32'(exp), 32'(act));
    endtask

    task automatic compare_upd(input string name, input op_update_t exp, input op_update_t act);
        if (act !== exp) report_mismatch({name, " update"}, 32'(exp), 32'(act));
    endtask

    task automatic compare_period(input string name, input int exp, input int act);
        if (act != exp) report_mismatch({name, " period"}, 32'(exp), 32'(act));
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
    endtask

    task automatic compare_all(input string name);
        compare_timer(name, exp_timer, timer);
        compare_lfo(name, exp_lfo, lfo);
        compare_test(name, exp_test, test);
        compare_pcm(name, exp_pcm, pcm);
        compare_upd(name, exp_upd, upd);
    endtask

    task automatic drive_idle();
        write = 1'b0;
        addr  = 2'b00;
        din   = 8'h00;
    endtask

    // Ends on the falling edge after the address write
    task automatic select_register(input logic part, input logic [7:0] sel);
        @(posedge clk);
        #2;
        write = 1'b1;
        addr  = {part, 1'b0};
        din   = sel;
        apply_select(sel);
        @(posedge clk);
        #2;
        drive_idle();
        @(negedge clk);
    endtask

    task automatic issue_access(input string name, input logic part, input logic [7:0] sel,
                                input logic [7:0] data);
        select_register(part, sel);
        compare_bit({name, " busy after address write"}, 1'b0, busy);
        @(posedge clk);     // Idle cycle gives write a rising edge
        #2;
        write = 1'b1;
        addr  = {part, 1'b1};
        din   = data;
        @(posedge clk);
        #2;
        drive_idle();
        apply_data_write(part, sel, data);
        @(negedge clk);
        compare_bit({name, " busy after data write"}, 1'b1, busy);
        compare_all(name);
    endtask

    task automatic finish_access(input string name, input int start);
        int n;
        int period;
        n = start;
        period = tick_period(exp_div);
        @(negedge clk);
        while (busy && n < BUSY_LIMIT) begin
            n++;
            @(negedge clk);
        end
        if (busy)
            report_error($sformatf("%s: busy still high after %0d cycles", name, n));
        if (n < 31 * period + 1 || n > 32 * period)
            report_error($sformatf("FAIL %s busy length: expected %0d..%0d, actual %0d",
                                   name, 31 * period + 1, 32 * period, n));
        clear_one_shots();
        compare_all({name, " after busy"});
    endtask

    task automatic host_write(input string name, input logic part, input logic [7:0] sel,
                              input logic [7:0] data);
        issue_access(name, part, sel, data);
        finish_access(name, 1);
    endtask

    // Checks the strobes right after the first idle tick
    task automatic oneshot_write(input string name, input logic [7:0] sel,
                                 input logic [7:0] data);
        int cycles;
        cycles = 1;
        issue_access(name, 1'b0, sel, data);
        while (!clk_en) begin
            @(negedge clk);
            cycles++;
        end
        @(negedge clk);
        clear_one_shots();
        compare_timer({name, " idle tick"}, exp_timer, timer);
        compare_pcm({name, " idle tick"}, exp_pcm, pcm);
        compare_bit({name, " busy at idle tick"}, 1'b1, busy);
        finish_access(name, cycles + 1);
    endtask

    task automatic measure_period(output int cycles);
        cycles = 1;
        while (!clk_en) @(negedge clk);
        @(negedge clk);
        while (!clk_en) begin
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic random_update_write(input string name);
        logic       part;
        logic [7:0] sel;
        part = 1'($urandom);
        sel  = ($urandom % 8 == 0) ? `FM_REG_KON : 8'h30 + 8'($urandom % 144);
        host_write(name, part, sel, 8'($urandom));
    endtask

    task automatic divider_step(input string name, input logic [7:0] sel);
        int period;
        select_register(1'b0, sel);
        compare_bit({name, " busy after select"}, 1'b0, busy);
        measure_period(period);
        compare_period(name, tick_period(exp_div), period);
        repeat (3) random_update_write({name, " write"});
    endtask

    initial begin
        int period;
        void'($urandom(32'hb882_e031));
        rst = 1'b1;
        drive_idle();
        reset_expected();
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;
        @(negedge clk);
        compare_all("reset");
        compare_bit("reset busy", 1'b0, busy);
        measure_period(period);
        compare_period("after reset", tick_period(exp_div), period);

        for (int i = 0; i < N_GLOBAL; i++)
            host_write("global", 1'($urandom), 8'h21 + 8'($urandom % 7), 8'($urandom));

        for (int i = 0; i < N_PCM; i++)
            host_write("pcm", $urandom % 4 == 0, 8'h2A + 8'($urandom % 3), 8'($urandom));

        for (int i = 0; i < N_ONESHOT; i++) begin
            if (i % 2 == 0)
                oneshot_write("timer clear", `FM_REG_TIMER, 8'($urandom) | 8'h30);
            else
                oneshot_write("pcm strobe", `FM_REG_PCM, 8'($urandom));
        end

        for (int i = 0; i < N_UPD; i++)
            random_update_write("update");

        divider_step("select 2E", `FM_REG_CLK_N3);
        divider_step("select 2F", `FM_REG_CLK_N2);
        divider_step("select 2D", `FM_REG_CLK_N6);

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+verilog
+incdir+tb
verilog/fm_pkg.sv
verilog/fm_bus_if.sv
verilog/fm_clk_div.sv
verilog/fm_global_regs.sv
verilog/fm_update_decode.sv
verilog/fm_mmr_top.sv
tb/fm_mmr_tb.sv

// File: Makefile
# Verilator build and run of the FM register front end testbench

SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = fm_mmr_tb
FILELIST = compile.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(wildcard verilog/*.sv verilog/*.svh tb/*.sv tb/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
